// ==== rtl/core_pkg.sv ====
// --------------------
// shared widths, ISA enums and stage bundles
// for the 16-bit in-order core
// --------------------
package core_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned XLEN       = 16;
  localparam int unsigned ILEN       = 16;
  localparam int unsigned PC_W       = 8;
  localparam int unsigned NR_REGS    = 8;
  localparam int unsigned REG_ADDR_W = 3;
  localparam int unsigned OPCODE_W   = 4;
  localparam int unsigned CSR_SEL_W  = 3;
  localparam int unsigned CAUSE_W    = 4;

  // addresses are in instruction words
  localparam logic [PC_W-1:0] BOOT_PC     = 8'h00;
  localparam logic [PC_W-1:0] TRAP_VECTOR = 8'hC0;

  // --------------------
  // ISA encodings
  // --------------------
  // opcode sits in instr[15:12], 8..15 are illegal
  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_LI   = 4'd5,
    OP_CSRR = 4'd6,
    OP_MRET = 4'd7
  } opcode_e;

  // csrr selector in instr[2:0]
  typedef enum logic [CSR_SEL_W-1:0] {
    CSR_INSTRET = 3'd0,
    CSR_MEPC    = 3'd1,
    CSR_MCAUSE  = 3'd2
  } csr_sel_e;

  typedef enum logic [CAUSE_W-1:0] {
    CAUSE_ILLEGAL_OP  = 4'd2,
    CAUSE_ILLEGAL_CSR = 4'd3
  } cause_e;

  // --------------------
  // stage bundles
  // --------------------
  typedef struct packed {
    logic [PC_W-1:0] pc;
    logic [ILEN-1:0] instr;
  } fetch_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [PC_W-1:0]       pc;
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    csr_sel_e              csr_sel;
    logic                  illegal;
    cause_e                cause;
  } exec_entry_t;

  typedef struct packed {
    logic                  valid;
    logic [PC_W-1:0]       pc;
    opcode_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
    csr_sel_e              csr_sel;
    logic                  illegal;
    cause_e                cause;
  } commit_entry_t;

endpackage

// ==== rtl/fetch_stage.sv ====
// --------------------
// PC generation and instruction fetch
// --------------------
module fetch_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic [core_pkg::PC_W-1:0] redirect_pc_i,
  input  logic [core_pkg::ILEN-1:0] instr_i,
  output logic [core_pkg::PC_W-1:0] instr_addr_o,
  output core_pkg::fetch_entry_t    fetch_entry_o
);

  import core_pkg::*;

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_d;

  // sequential fetch unless commit redirects us
  always_comb begin
    if (flush_i) begin
      pc_d = redirect_pc_i;
    end else begin
      pc_d = pc_q + PC_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // ROM answers in the same cycle
  assign instr_addr_o        = pc_q;
  assign fetch_entry_o.pc    = pc_q;
  assign fetch_entry_o.instr = instr_i;

endmodule

// ==== rtl/id_stage.sv ====
// --------------------
// decode, legality check, register file
// and write-back forwarding
// --------------------
module id_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  core_pkg::fetch_entry_t          fetch_entry_i,
  input  logic                            wb_we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [core_pkg::XLEN-1:0]       wb_data_i,
  output core_pkg::exec_entry_t           exec_entry_o
);

  import core_pkg::*;

  fetch_entry_t          fetch_q;
  logic                  valid_q;
  logic [XLEN-1:0]       regs_q [NR_REGS];

  opcode_e               op;
  csr_sel_e              csr_sel;
  logic                  illegal;
  cause_e                cause;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic [XLEN-1:0]       imm;

  // --------------------
  // fetch register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      // word fetched during a flush is on the wrong path
      valid_q <= !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    fetch_q <= fetch_entry_i;
  end

  // --------------------
  // decode
  // --------------------
  assign op       = opcode_e'(fetch_q.instr[15:12]);
  assign csr_sel  = csr_sel_e'(fetch_q.instr[2:0]);
  assign rs1_addr = fetch_q.instr[8:6];
  assign rs2_addr = fetch_q.instr[5:3];
  assign imm      = XLEN'(fetch_q.instr[7:0]);

  always_comb begin
    illegal = 1'b0;
    cause   = CAUSE_ILLEGAL_OP;
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LI, OP_MRET: illegal = 1'b0;
      OP_CSRR: begin
        case (csr_sel)
          CSR_INSTRET, CSR_MEPC, CSR_MCAUSE: illegal = 1'b0;
          default: begin
            illegal = 1'b1;
            cause   = CAUSE_ILLEGAL_CSR;
          end
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // --------------------
  // register file
  // --------------------
  always_ff @(posedge clk_i) begin
    if (wb_we_i) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  // the instruction in commit writes at the end of this cycle
  assign rs1_data = (wb_we_i && wb_rd_i == rs1_addr) ? wb_data_i : regs_q[rs1_addr];
  assign rs2_data = (wb_we_i && wb_rd_i == rs2_addr) ? wb_data_i : regs_q[rs2_addr];

  always_comb begin
    exec_entry_o.valid     = valid_q;
    exec_entry_o.pc        = fetch_q.pc;
    exec_entry_o.op        = op;
    exec_entry_o.rd        = fetch_q.instr[11:9];
    exec_entry_o.operand_a = rs1_data;
    // LI carries its immediate in operand b
    exec_entry_o.operand_b = (op == OP_LI) ? imm : rs2_data;
    exec_entry_o.csr_sel   = csr_sel;
    exec_entry_o.illegal   = illegal;
    exec_entry_o.cause     = cause;
  end

endmodule

// ==== rtl/ex_stage.sv ====
// --------------------
// ALU and execute-to-commit register
// --------------------
module ex_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  core_pkg::exec_entry_t   exec_entry_i,
  output core_pkg::commit_entry_t commit_entry_o
);

  import core_pkg::*;

  logic [XLEN-1:0] alu_result;
  commit_entry_t   commit_d;
  commit_entry_t   commit_q;
  logic            valid_q;

  always_comb begin
    case (exec_entry_i.op)
      OP_ADD:  alu_result = exec_entry_i.operand_a + exec_entry_i.operand_b;
      OP_SUB:  alu_result = exec_entry_i.operand_a - exec_entry_i.operand_b;
      OP_AND:  alu_result = exec_entry_i.operand_a & exec_entry_i.operand_b;
      OP_OR:   alu_result = exec_entry_i.operand_a | exec_entry_i.operand_b;
      OP_XOR:  alu_result = exec_entry_i.operand_a ^ exec_entry_i.operand_b;
      OP_LI:   alu_result = exec_entry_i.operand_b;
      // csrr result comes from the csr file at commit
      default: alu_result = '0;
    endcase
  end

  always_comb begin
    commit_d.valid   = exec_entry_i.valid;
    commit_d.pc      = exec_entry_i.pc;
    commit_d.op      = exec_entry_i.op;
    commit_d.rd      = exec_entry_i.rd;
    commit_d.result  = alu_result;
    commit_d.csr_sel = exec_entry_i.csr_sel;
    commit_d.illegal = exec_entry_i.illegal;
    commit_d.cause   = exec_entry_i.cause;
  end

  // --------------------
  // pipeline register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= commit_d.valid && !flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    commit_q <= commit_d;
  end

  always_comb begin
    commit_entry_o       = commit_q;
    commit_entry_o.valid = valid_q;
  end

endmodule

// ==== rtl/commit_stage.sv ====
// --------------------
// retirement, write-back and trap/return redirect
// --------------------
module commit_stage (
  input  core_pkg::commit_entry_t         commit_entry_i,
  input  logic [core_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic [core_pkg::PC_W-1:0]       mepc_i,
  output logic                            wb_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [core_pkg::XLEN-1:0]       wb_data_o,
  output logic                            retire_o,
  output logic                            trap_o,
  output logic [core_pkg::PC_W-1:0]       trap_pc_o,
  output core_pkg::cause_e                trap_cause_o,
  output logic                            flush_o,
  output logic [core_pkg::PC_W-1:0]       redirect_pc_o,
  output core_pkg::csr_sel_e              csr_sel_o
);

  import core_pkg::*;

  logic is_mret;

  assign is_mret = commit_entry_i.op == OP_MRET;

  // a valid entry either retires or traps
  assign retire_o = commit_entry_i.valid && !commit_entry_i.illegal;
  assign trap_o   = commit_entry_i.valid && commit_entry_i.illegal;

  // --------------------
  // write-back
  // --------------------
  assign csr_sel_o = commit_entry_i.csr_sel;
  assign wb_we_o   = retire_o && !is_mret;
  assign wb_rd_o   = commit_entry_i.rd;
  assign wb_data_o = (commit_entry_i.op == OP_CSRR) ? csr_rdata_i : commit_entry_i.result;

  assign trap_pc_o    = commit_entry_i.pc;
  assign trap_cause_o = commit_entry_i.cause;

  // --------------------
  // redirect
  // --------------------
  // mret resumes after the faulting word
  assign flush_o       = trap_o || (retire_o && is_mret);
  assign redirect_pc_o = trap_o ? TRAP_VECTOR : mepc_i + PC_W'(1);

endmodule

// ==== rtl/csr_regfile.sv ====
// --------------------
// mepc, mcause and retired-instruction counter
// --------------------
module csr_regfile (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      retire_i,
  input  logic                      trap_i,
  input  logic [core_pkg::PC_W-1:0] trap_pc_i,
  input  core_pkg::cause_e          trap_cause_i,
  input  core_pkg::csr_sel_e        csr_sel_i,
  output logic [core_pkg::XLEN-1:0] csr_rdata_o,
  output logic [core_pkg::PC_W-1:0] mepc_o
);

  import core_pkg::*;

  logic [XLEN-1:0]    instret_q;
  logic [PC_W-1:0]    mepc_q;
  logic [CAUSE_W-1:0] mcause_q;

  // --------------------
  // instret
  // --------------------
  // mret counts, trapped words do not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instret_q <= '0;
    end else if (retire_i) begin
      instret_q <= instret_q + XLEN'(1);
    end
  end

  // --------------------
  // trap state
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (trap_i) begin
      mepc_q   <= trap_pc_i;
      mcause_q <= trap_cause_i;
    end
  end

  // --------------------
  // read port
  // --------------------
  always_comb begin
    case (csr_sel_i)
      CSR_INSTRET: csr_rdata_o = instret_q;
      CSR_MEPC:    csr_rdata_o = XLEN'(mepc_q);
      CSR_MCAUSE:  csr_rdata_o = XLEN'(mcause_q);
      // unknown selectors trap before they get here
      default:     csr_rdata_o = '0;
    endcase
  end

  // return target for mret
  assign mepc_o = mepc_q;

endmodule

// ==== rtl/core_top.sv ====
// --------------------
// core top level
// fetch, decode, execute, commit and CSR file
// --------------------
module core_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [core_pkg::ILEN-1:0]       instr_i,
  output logic [core_pkg::PC_W-1:0]       instr_addr_o,
  output logic                            commit_valid_o,
  output logic [core_pkg::PC_W-1:0]       commit_pc_o,
  output logic                            commit_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
  output logic [core_pkg::XLEN-1:0]       commit_wdata_o,
  output logic                            trap_o,
  output logic [core_pkg::PC_W-1:0]       trap_pc_o,
  output core_pkg::cause_e                trap_cause_o
);

  import core_pkg::*;

  // --------------------
  // stage bundles
  // --------------------
  fetch_entry_t          fetch_entry_if_id;
  exec_entry_t           exec_entry_id_ex;
  commit_entry_t         commit_entry_ex_commit;

  // commit to the rest of the core
  logic                  flush_commit;
  logic [PC_W-1:0]       redirect_pc_commit_if;
  logic                  wb_we_commit_id;
  logic [REG_ADDR_W-1:0] wb_rd_commit_id;
  logic [XLEN-1:0]       wb_data_commit_id;
  logic                  retire_commit_csr;
  logic                  trap_commit_csr;
  logic [PC_W-1:0]       trap_pc_commit_csr;
  cause_e                trap_cause_commit_csr;
  csr_sel_e              csr_sel_commit_csr;
  logic [XLEN-1:0]       csr_rdata_csr_commit;
  logic [PC_W-1:0]       mepc_csr_commit;

  fetch_stage i_fetch_stage (
    .clk_i         ( clk_i                 ),
    .rst_ni        ( rst_ni                ),
    .flush_i       ( flush_commit          ),
    .redirect_pc_i ( redirect_pc_commit_if ),
    .instr_i       ( instr_i               ),
    .instr_addr_o  ( instr_addr_o          ),
    .fetch_entry_o ( fetch_entry_if_id     )
  );

  id_stage i_id_stage (
    .clk_i         ( clk_i             ),
    .rst_ni        ( rst_ni            ),
    .flush_i       ( flush_commit      ),
    .fetch_entry_i ( fetch_entry_if_id ),
    .wb_we_i       ( wb_we_commit_id   ),
    .wb_rd_i       ( wb_rd_commit_id   ),
    .wb_data_i     ( wb_data_commit_id ),
    .exec_entry_o  ( exec_entry_id_ex  )
  );

  ex_stage i_ex_stage (
    .clk_i          ( clk_i                  ),
    .rst_ni         ( rst_ni                 ),
    .flush_i        ( flush_commit           ),
    .exec_entry_i   ( exec_entry_id_ex       ),
    .commit_entry_o ( commit_entry_ex_commit )
  );

  commit_stage i_commit_stage (
    .commit_entry_i ( commit_entry_ex_commit ),
    .csr_rdata_i    ( csr_rdata_csr_commit   ),
    .mepc_i         ( mepc_csr_commit        ),
    .wb_we_o        ( wb_we_commit_id        ),
    .wb_rd_o        ( wb_rd_commit_id        ),
    .wb_data_o      ( wb_data_commit_id      ),
    .retire_o       ( retire_commit_csr      ),
    .trap_o         ( trap_commit_csr        ),
    .trap_pc_o      ( trap_pc_commit_csr     ),
    .trap_cause_o   ( trap_cause_commit_csr  ),
    .flush_o        ( flush_commit           ),
    .redirect_pc_o  ( redirect_pc_commit_if  ),
    .csr_sel_o      ( csr_sel_commit_csr     )
  );

  csr_regfile i_csr_regfile (
    .clk_i        ( clk_i                 ),
    .rst_ni       ( rst_ni                ),
    .retire_i     ( retire_commit_csr     ),
    .trap_i       ( trap_commit_csr       ),
    .trap_pc_i    ( trap_pc_commit_csr    ),
    .trap_cause_i ( trap_cause_commit_csr ),
    .csr_sel_i    ( csr_sel_commit_csr    ),
    .csr_rdata_o  ( csr_rdata_csr_commit  ),
    .mepc_o       ( mepc_csr_commit       )
  );

  // --------------------
  // commit port
  // --------------------
  assign commit_valid_o = retire_commit_csr;
  assign commit_pc_o    = commit_entry_ex_commit.pc;
  assign commit_we_o    = wb_we_commit_id;
  assign commit_rd_o    = wb_rd_commit_id;
  assign commit_wdata_o = wb_data_commit_id;
  assign trap_o         = trap_commit_csr;
  assign trap_pc_o      = trap_pc_commit_csr;
  assign trap_cause_o   = trap_cause_commit_csr;

endmodule

// ==== tests/tb_core.sv ====
// --------------------
// clock, reset, random ROM, architectural reference model
// and checking assertions for core_top
// --------------------
module tb_core;

  timeunit 1ns;
  timeprecision 1ps;

  import core_pkg::*;

  localparam int unsigned CLK_HALF       = 20;
  localparam int unsigned RESET_CYCLES   = 4;
  localparam int unsigned RAND_SEED      = 18;
  localparam int unsigned NUM_RETIRE     = 400;
  localparam int unsigned RETIRE_TIMEOUT = 20;

  logic                  clk_i;
  logic                  rst_ni;
  logic [ILEN-1:0]       instr_i;
  logic [PC_W-1:0]       instr_addr_o;
  logic                  commit_valid_o;
  logic [PC_W-1:0]       commit_pc_o;
  logic                  commit_we_o;
  logic [REG_ADDR_W-1:0] commit_rd_o;
  logic [XLEN-1:0]       commit_wdata_o;
  logic                  trap_o;
  logic [PC_W-1:0]       trap_pc_o;
  cause_e                trap_cause_o;

  logic [ILEN-1:0]       rom [2**PC_W];

  // architectural state of the reference model
  logic [XLEN-1:0]       m_regs [NR_REGS];
  logic [PC_W-1:0]       m_pc;
  logic [XLEN-1:0]       m_instret;
  logic [PC_W-1:0]       m_mepc;
  logic [CAUSE_W-1:0]    m_mcause;
  int unsigned           retire_count;
  logic [1:0]            rst_hist_q;
  logic                  redirect_q;

  logic [ILEN-1:0]       exp_instr;
  logic [XLEN-1:0]       src_a;
  logic [XLEN-1:0]       src_b;
  logic                  exp_illegal;
  logic [CAUSE_W-1:0]    exp_cause;
  logic                  exp_we;
  logic [REG_ADDR_W-1:0] exp_rd;
  logic [XLEN-1:0]       exp_wdata;
  logic [PC_W-1:0]       exp_next_pc;

  logic                  timed_out;

  core_top u_dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_i        ( instr_i        ),
    .instr_addr_o   ( instr_addr_o   ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_we_o    ( commit_we_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o ),
    .trap_o         ( trap_o         ),
    .trap_pc_o      ( trap_pc_o      ),
    .trap_cause_o   ( trap_cause_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  // ROM answers with the word at the current fetch address
  initial begin
    instr_i = '0;
    forever begin
      @(negedge clk_i);
      instr_i = rom[instr_addr_o];
    end
  end

  // --------------------
  // program generation
  // --------------------
  function automatic logic [ILEN-1:0] li_word(input logic [REG_ADDR_W-1:0] rd,
                                              input logic [7:0] imm);
    return {OP_LI, rd, 1'b0, imm};
  endfunction

  // mostly legal words with about one in eight trapping
  function automatic logic [ILEN-1:0] random_word();
    int unsigned     kind;
    logic [ILEN-1:0] word;
    kind = $urandom_range(0, 31);
    word = ILEN'($urandom);
    if (kind < 2) begin
      word[15:12] = 4'($urandom_range(8, 15));
    end else if (kind < 4) begin
      word[15:12] = OP_CSRR;
      word[2:0]   = 3'($urandom_range(3, 7));
    end else if (kind < 8) begin
      word[15:12] = OP_CSRR;
      word[2:0]   = 3'($urandom_range(0, 2));
    end else if (kind < 14) begin
      word[15:12] = OP_LI;
    end else begin
      word[15:12] = 4'($urandom_range(0, 4));
    end
    return word;
  endfunction

  task automatic fill_rom();
    for (int a = 0; a < 2**PC_W; a++) begin
      rom[PC_W'(a)] = random_word();
    end
    // give every register a known value on each pass through address 0
    for (int r = 0; r < NR_REGS; r++) begin
      rom[PC_W'(r)] = li_word(REG_ADDR_W'(r), 8'($urandom));
    end
    // a trap right before the handler would loop on mret
    rom[TRAP_VECTOR - 8'd1] = li_word(3'd7, 8'h5a);
    rom[TRAP_VECTOR]        = {OP_CSRR, 3'd1, 6'd0, CSR_MCAUSE};
    rom[TRAP_VECTOR + 8'd1] = {OP_CSRR, 3'd2, 6'd0, CSR_MEPC};
    rom[TRAP_VECTOR + 8'd2] = {OP_MRET, 12'h000};
  endtask

  // --------------------
  // reference model
  // --------------------
  always_comb begin
    exp_instr   = rom[m_pc];
    exp_rd      = exp_instr[11:9];
    src_a       = m_regs[exp_instr[8:6]];
    src_b       = m_regs[exp_instr[5:3]];
    exp_illegal = 1'b0;
    exp_cause   = CAUSE_ILLEGAL_OP;
    exp_we      = 1'b1;
    exp_wdata   = '0;
    exp_next_pc = m_pc + 8'd1;
    case (exp_instr[15:12])
      OP_ADD:  exp_wdata = src_a + src_b;
      OP_SUB:  exp_wdata = src_a - src_b;
      OP_AND:  exp_wdata = src_a & src_b;
      OP_OR:   exp_wdata = src_a | src_b;
      OP_XOR:  exp_wdata = src_a ^ src_b;
      OP_LI:   exp_wdata = {8'h00, exp_instr[7:0]};
      OP_CSRR: begin
        case (exp_instr[2:0])
          CSR_INSTRET: exp_wdata = m_instret;
          CSR_MEPC:    exp_wdata = {8'h00, m_mepc};
          CSR_MCAUSE:  exp_wdata = {12'h000, m_mcause};
          default: begin
            exp_illegal = 1'b1;
            exp_cause   = CAUSE_ILLEGAL_CSR;
          end
        endcase
      end
      OP_MRET: begin
        exp_we      = 1'b0;
        exp_next_pc = m_mepc + 8'd1;
      end
      default: exp_illegal = 1'b1;
    endcase
    if (exp_illegal) begin
      exp_we      = 1'b0;
      exp_next_pc = TRAP_VECTOR;
    end
  end

  // one architectural step per retirement or trap
  always @(posedge clk_i) begin
    rst_hist_q <= {rst_hist_q[0], rst_ni};
    if (!rst_ni) begin
      m_pc         <= BOOT_PC;
      m_instret    <= '0;
      m_mepc       <= '0;
      m_mcause     <= '0;
      retire_count <= 0;
      redirect_q   <= 1'b0;
      for (int r = 0; r < NR_REGS; r++) begin
        m_regs[REG_ADDR_W'(r)] <= '0;
      end
    end else begin
      // trap and mret restart fetch at the model's next pc
      redirect_q <= (commit_valid_o || trap_o) &&
                    (exp_illegal || exp_instr[15:12] == OP_MRET);
      if (commit_valid_o || trap_o) begin
        if (exp_we) begin
          m_regs[exp_rd] <= exp_wdata;
        end
        if (exp_illegal) begin
          m_mepc   <= m_pc;
          m_mcause <= exp_cause;
        end else begin
          m_instret <= m_instret + 16'd1;
        end
        if (commit_valid_o) begin
          retire_count <= retire_count + 1;
        end
        m_pc <= exp_next_pc;
      end
    end
  end

  // --------------------
  // checks
  // --------------------
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopping at the first error");
  endtask

  quiet_after_reset: assert property (@(posedge clk_i)
    (rst_hist_q != 2'b11) |-> (!commit_valid_o && !trap_o))
    else report_failure("commit or trap pulse during reset or in the first cycle after it");

  one_event_per_cycle: assert property (@(posedge clk_i) !(commit_valid_o && trap_o))
    else report_failure("retirement and trap reported in the same cycle");

  retire_is_legal: assert property (@(posedge clk_i) commit_valid_o |-> !exp_illegal)
    else report_failure("instruction retired where the model expects a trap");

  trap_is_illegal: assert property (@(posedge clk_i) trap_o |-> exp_illegal)
    else report_failure("trap raised on an instruction the model treats as legal");

  commit_pc_match: assert property (@(posedge clk_i) commit_valid_o |-> commit_pc_o == m_pc)
    else report_failure($sformatf("Mismatch commit_pc_o: got 0x%h expected 0x%h",
                                  $sampled(commit_pc_o), $sampled(m_pc)));

  commit_we_match: assert property (@(posedge clk_i)
    (commit_valid_o || trap_o) |-> commit_we_o == exp_we)
    else report_failure($sformatf("Mismatch commit_we_o: got 0x%h expected 0x%h",
                                  $sampled(commit_we_o), $sampled(exp_we)));

  commit_rd_match: assert property (@(posedge clk_i)
    (commit_valid_o && exp_we) |-> commit_rd_o == exp_rd)
    else report_failure($sformatf("Mismatch commit_rd_o: got 0x%h expected 0x%h",
                                  $sampled(commit_rd_o), $sampled(exp_rd)));

  commit_wdata_match: assert property (@(posedge clk_i)
    (commit_valid_o && exp_we) |-> commit_wdata_o == exp_wdata)
    else report_failure($sformatf("Mismatch commit_wdata_o: got 0x%h expected 0x%h",
                                  $sampled(commit_wdata_o), $sampled(exp_wdata)));

  trap_pc_match: assert property (@(posedge clk_i) trap_o |-> trap_pc_o == m_pc)
    else report_failure($sformatf("Mismatch trap_pc_o: got 0x%h expected 0x%h",
                                  $sampled(trap_pc_o), $sampled(m_pc)));

  trap_cause_match: assert property (@(posedge clk_i) trap_o |-> trap_cause_o == exp_cause)
    else report_failure($sformatf("Mismatch trap_cause_o: got 0x%h expected 0x%h",
                                  $sampled(trap_cause_o), $sampled(exp_cause)));

  // redirect target is on the fetch port one cycle after the trap or mret
  redirect_fetch_match: assert property (@(posedge clk_i)
    redirect_q |-> instr_addr_o == m_pc)
    else report_failure($sformatf("Mismatch instr_addr_o: got 0x%h expected 0x%h",
                                  $sampled(instr_addr_o), $sampled(m_pc)));

  // --------------------
  // run control
  // --------------------
  task automatic wait_for_retirement(input int unsigned target, output logic expired);
    int unsigned cycles;
    cycles  = 0;
    expired = 1'b0;
    while (retire_count < target && !expired) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > RETIRE_TIMEOUT) begin
        expired = 1'b1;
      end
    end
  endtask

  initial begin
    rst_ni    = 1'b0;
    timed_out = 1'b0;
    void'($urandom(RAND_SEED));
    fill_rom();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int unsigned n = 1; n <= NUM_RETIRE && !timed_out; n++) begin
      wait_for_retirement(n, timed_out);
    end
    if (timed_out) begin
      $display("no retirement within %0d cycles after %0d retirements",
               RETIRE_TIMEOUT, retire_count);
      $display("Something failed");
      $fatal(1, "run aborted on timeout");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/commit_stage.sv
rtl/csr_regfile.sv
rtl/core_top.sv
tests/tb_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_core
RTL_TOP    ?= core_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= $(shell grep '^rtl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAIL: no verdict in $(LOG)"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
